// File: src/bus_pkg.sv
package bus_pkg;

  // arbiter FSM, one transaction in flight at a time
  typedef enum logic [2:0] {
    arb_idle       = 3'd0,
    // fetch read outstanding
    arb_fetch      = 3'd1,
    // load read outstanding
    arb_load       = 3'd2,
    // write data phase
    arb_store_data = 3'd3,
    // waiting for write response
    arb_store_resp = 3'd4,
    // timer read outstanding
    arb_timer      = 3'd5
  } arb_state_t;

  // AXI size field, bytes per beat as log2
  typedef enum logic [2:0] {
    size_byte = 3'b000,
    size_half = 3'b001,
    size_word = 3'b010
  } axi_size_t;

  // core-local timer, mtime split into two word addresses
  localparam logic [31:0] CLINT_MTIME_LO = 32'h0200_BFF8;
  localparam logic [31:0] CLINT_MTIME_HI = 32'h0200_BFFC;

endpackage

// File: src/lane_align.sv
`timescale 1ns/1ps

module lane_align #(
  parameter int ADDR_W = 32
) (
  // read side
  input  logic [ADDR_W-1:0]  rd_addr_i,
  input  logic [7:0]         rd_strb_i,
  input  logic               rd_lsu_i,
  input  logic               rd_timer_i,
  input  logic [63:0]        m_rdata_i,
  input  logic [31:0]        tmr_rdata_i,
  output bus_pkg::axi_size_t m_arsize_o,
  output logic [31:0]        rd_data_o,

  // write side
  input  logic [ADDR_W-1:0]  wr_addr_i,
  input  logic [31:0]        lsu_wdata_i,
  input  logic [7:0]         lsu_wstrb_i,
  output bus_pkg::axi_size_t m_awsize_o,
  output logic [63:0]        m_wdata_o,
  output logic [7:0]         m_wstrb_o
);
  import bus_pkg::*;

  logic [31:0] bus_word;
  logic [31:0] wdata_sh;
  logic [3:0]  wstrb_sh;

  // byte, half and word strobes; anything odd goes out as a byte
  function automatic axi_size_t strb_to_size(input logic [3:0] strb);
    axi_size_t size;
    unique case (strb)
      4'h1:    size = size_byte;
      4'h3:    size = size_half;
      4'hf:    size = size_word;
      default: size = size_byte;
    endcase
    return size;
  endfunction

  // fetch is always a full word
  assign m_arsize_o = rd_lsu_i ? strb_to_size(rd_strb_i[3:0]) : size_word;
  assign m_awsize_o = strb_to_size(lsu_wstrb_i[3:0]);

  // lane pick by address bit 2
  assign bus_word  = rd_addr_i[2] ? m_rdata_i[63:32] : m_rdata_i[31:0];
  assign rd_data_o = rd_timer_i ? tmr_rdata_i : bus_word;

  // shift by byte offset, then mirror into both lanes
  assign wdata_sh  = lsu_wdata_i << {wr_addr_i[1:0], 3'b000};
  assign m_wdata_o = {wdata_sh, wdata_sh};

  // strobe goes to the nibble of the addressed lane
  assign wstrb_sh  = lsu_wstrb_i[3:0] << wr_addr_i[1:0];
  assign m_wstrb_o = wr_addr_i[2] ? {wstrb_sh, 4'b0000} : {4'b0000, wstrb_sh};

endmodule

// File: src/clint_timer.sv
`timescale 1ns/1ps

module clint_timer #(
  parameter int CLINT_DIV = 4
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        tmr_rd_i,
  input  logic        tmr_hi_i,
  output logic [31:0] tmr_rdata_o,
  output logic        tmr_rvalid_o
);

  // one extra bit keeps the width nonzero for a divider of 1
  localparam int DIV_W = $clog2(CLINT_DIV + 1);

  logic [DIV_W-1:0] div_cnt;
  logic [63:0]      mtime;
  logic             tick;

  assign tick = (div_cnt == DIV_W'(CLINT_DIV - 1));

  // prescaler and mtime
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      div_cnt <= '0;
      mtime   <= '0;
    end
    else if (tick)
    begin
      div_cnt <= '0;
      mtime   <= mtime + 64'd1;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tmr_rvalid_o <= 1'b0;
    end
    else
    begin
      tmr_rvalid_o <= tmr_rd_i;
    end
  end

  // captures mtime as seen on the read edge
  always_ff @(posedge clk)
  begin
    if (tmr_rd_i)
    begin
      tmr_rdata_o <= tmr_hi_i ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

// File: src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst,

  // fetch read request
  input  logic              ifu_arvalid_i,
  input  logic [ADDR_W-1:0] ifu_araddr_i,
  output logic              ifu_rvalid_o,

  // load read request
  input  logic              lsu_arvalid_i,
  input  logic [ADDR_W-1:0] lsu_araddr_i,
  output logic              lsu_rvalid_o,

  // store request
  input  logic              lsu_awvalid_i,
  input  logic [ADDR_W-1:0] lsu_awaddr_i,
  output logic              lsu_wready_o,

  // AXI master channel control
  output logic              m_arvalid_o,
  input  logic              m_arready_i,
  output logic [ADDR_W-1:0] m_araddr_o,
  input  logic              m_rvalid_i,
  output logic              m_awvalid_o,
  input  logic              m_awready_i,
  output logic [ADDR_W-1:0] m_awaddr_o,
  output logic              m_wvalid_o,
  input  logic              m_wready_i,
  input  logic              m_bvalid_i,

  // timer read port
  output logic              tmr_rd_o,
  output logic              tmr_hi_o,
  input  logic              tmr_rvalid_i,

  // read ownership for the data path
  output logic              rd_lsu_o,
  output logic              rd_timer_o
);
  import bus_pkg::*;

  arb_state_t state;

  // set while a fetch sits on AR without ready, so a late load cannot steal the bus
  logic fetch_lock_q;

  logic is_idle;
  logic ld_is_lo;
  logic ld_is_hi;
  logic ld_is_timer;
  logic sel_store;
  logic sel_load;
  logic sel_fetch;

  assign is_idle = (state == arb_idle);

  // timer decode on the load address
  assign ld_is_lo    = (lsu_araddr_i == ADDR_W'(CLINT_MTIME_LO));
  assign ld_is_hi    = (lsu_araddr_i == ADDR_W'(CLINT_MTIME_HI));
  assign ld_is_timer = ld_is_lo | ld_is_hi;

  // load/store win over fetch unless a fetch is already presented
  assign sel_store = lsu_awvalid_i & ~fetch_lock_q;
  assign sel_load  = lsu_arvalid_i & ~fetch_lock_q;
  assign sel_fetch = ifu_arvalid_i & (fetch_lock_q | (~lsu_arvalid_i & ~lsu_awvalid_i));

  assign m_arvalid_o = is_idle & ((sel_load & ~ld_is_timer) | sel_fetch);
  assign m_awvalid_o = is_idle & sel_store;
  assign m_wvalid_o  = (state == arb_store_data);

  assign rd_lsu_o   = is_idle ? sel_load : ((state == arb_load) | (state == arb_timer));
  assign rd_timer_o = (state == arb_timer);

  // requesters hold their address until the strobe
  assign m_araddr_o = rd_lsu_o ? lsu_araddr_i : ifu_araddr_i;
  assign m_awaddr_o = lsu_awaddr_i;

  // response strobes back to the core
  assign ifu_rvalid_o = (state == arb_fetch) & m_rvalid_i;
  assign lsu_rvalid_o = ((state == arb_load) & m_rvalid_i) |
                        ((state == arb_timer) & tmr_rvalid_i);
  assign lsu_wready_o = (state == arb_store_resp) & m_bvalid_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= arb_idle;
      fetch_lock_q <= 1'b0;
      tmr_rd_o     <= 1'b0;
      tmr_hi_o     <= 1'b0;
    end
    else
    begin
      tmr_rd_o     <= 1'b0;
      fetch_lock_q <= 1'b0;
      unique case (state)
        arb_idle:
        begin
          if (sel_load & ld_is_timer)
          begin
            // timer load never reaches AXI
            state    <= arb_timer;
            tmr_rd_o <= 1'b1;
            tmr_hi_o <= ld_is_hi;
          end
          else if (m_arvalid_o & m_arready_i)
          begin
            state <= rd_lsu_o ? arb_load : arb_fetch;
          end
          else if (m_awvalid_o & m_awready_i)
          begin
            state <= arb_store_data;
          end
          else
          begin
            fetch_lock_q <= sel_fetch;
          end
        end
        arb_fetch, arb_load:
        begin
          if (m_rvalid_i)
          begin
            state <= arb_idle;
          end
        end
        arb_store_data:
        begin
          if (m_wready_i)
          begin
            state <= arb_store_resp;
          end
        end
        arb_store_resp:
        begin
          if (m_bvalid_i)
          begin
            state <= arb_idle;
          end
        end
        arb_timer:
        begin
          if (tmr_rvalid_i)
          begin
            state <= arb_idle;
          end
        end
        default:
        begin
          state <= arb_idle;
        end
      endcase
    end
  end

endmodule

// File: src/bus_top.sv
`timescale 1ns/1ps

module bus_top #(
  parameter int ADDR_W    = 32,
  parameter int CLINT_DIV = 4
) (
  input  logic               clk,
  input  logic               rst,

  // fetch
  input  logic               ifu_arvalid_i,
  input  logic [ADDR_W-1:0]  ifu_araddr_i,
  output logic [31:0]        ifu_rdata_o,
  output logic               ifu_rvalid_o,

  // load
  input  logic               lsu_arvalid_i,
  input  logic [ADDR_W-1:0]  lsu_araddr_i,
  input  logic [7:0]         lsu_rstrb_i,
  output logic [31:0]        lsu_rdata_o,
  output logic               lsu_rvalid_o,

  // store
  input  logic               lsu_awvalid_i,
  input  logic [ADDR_W-1:0]  lsu_awaddr_i,
  input  logic [31:0]        lsu_wdata_i,
  input  logic [7:0]         lsu_wstrb_i,
  output logic               lsu_wready_o,

  // AXI master
  output logic               m_arvalid_o,
  input  logic               m_arready_i,
  output logic [ADDR_W-1:0]  m_araddr_o,
  output bus_pkg::axi_size_t m_arsize_o,
  input  logic               m_rvalid_i,
  input  logic [63:0]        m_rdata_i,
  output logic               m_rready_o,
  output logic               m_awvalid_o,
  input  logic               m_awready_i,
  output logic [ADDR_W-1:0]  m_awaddr_o,
  output bus_pkg::axi_size_t m_awsize_o,
  output logic               m_wvalid_o,
  input  logic               m_wready_i,
  output logic [63:0]        m_wdata_o,
  output logic [7:0]         m_wstrb_o,
  output logic               m_wlast_o,
  input  logic               m_bvalid_i,
  output logic               m_bready_o
);

  logic        tmr_rd;
  logic        tmr_hi;
  logic        tmr_rvalid;
  logic [31:0] tmr_rdata;
  logic        rd_lsu;
  logic        rd_timer;
  logic [31:0] rd_data;

  // single-beat transfers, responses always accepted
  assign m_wlast_o  = 1'b1;
  assign m_rready_o = 1'b1;
  assign m_bready_o = 1'b1;

  // both read ports share the aligned word, the strobes tell them apart
  assign ifu_rdata_o = rd_data;
  assign lsu_rdata_o = rd_data;

  bus_arbiter #(
    .ADDR_W (ADDR_W)
  ) i_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wready_o  (lsu_wready_o),
    .m_arvalid_o   (m_arvalid_o),
    .m_arready_i   (m_arready_i),
    .m_araddr_o    (m_araddr_o),
    .m_rvalid_i    (m_rvalid_i),
    .m_awvalid_o   (m_awvalid_o),
    .m_awready_i   (m_awready_i),
    .m_awaddr_o    (m_awaddr_o),
    .m_wvalid_o    (m_wvalid_o),
    .m_wready_i    (m_wready_i),
    .m_bvalid_i    (m_bvalid_i),
    .tmr_rd_o      (tmr_rd),
    .tmr_hi_o      (tmr_hi),
    .tmr_rvalid_i  (tmr_rvalid),
    .rd_lsu_o      (rd_lsu),
    .rd_timer_o    (rd_timer)
  );

  lane_align #(
    .ADDR_W (ADDR_W)
  ) i_align (
    .rd_addr_i   (m_araddr_o),
    .rd_strb_i   (lsu_rstrb_i),
    .rd_lsu_i    (rd_lsu),
    .rd_timer_i  (rd_timer),
    .m_rdata_i   (m_rdata_i),
    .tmr_rdata_i (tmr_rdata),
    .m_arsize_o  (m_arsize_o),
    .rd_data_o   (rd_data),
    .wr_addr_i   (m_awaddr_o),
    .lsu_wdata_i (lsu_wdata_i),
    .lsu_wstrb_i (lsu_wstrb_i),
    .m_awsize_o  (m_awsize_o),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o)
  );

  clint_timer #(
    .CLINT_DIV (CLINT_DIV)
  ) i_timer (
    .clk          (clk),
    .rst          (rst),
    .tmr_rd_i     (tmr_rd),
    .tmr_hi_i     (tmr_hi),
    .tmr_rdata_o  (tmr_rdata),
    .tmr_rvalid_o (tmr_rvalid)
  );

endmodule

// File: verification/bus_assertions.sv
`timescale 1ns/1ps

module bus_assertions #(
  parameter int ADDR_W = 32
) (
  input logic               clk,
  input logic               rst,
  input bus_pkg::arb_state_t state,
  input logic               m_arvalid_o,
  input logic               m_arready_i,
  input logic [ADDR_W-1:0]  m_araddr_o,
  input logic               m_awvalid_o,
  input logic               m_awready_i,
  input logic [ADDR_W-1:0]  m_awaddr_o,
  input logic               m_wvalid_o
);
  import bus_pkg::*;

  // one address channel at a time
  a_single_addr: assert property (@(posedge clk) disable iff (rst)
    !(m_arvalid_o && m_awvalid_o))
    else $error("AR and AW valid in the same cycle");

  // pending read address holds until accepted
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    (m_arvalid_o && !m_arready_i) |=> (m_arvalid_o && $stable(m_araddr_o)))
    else $error("AR valid or address changed before ready");

  // pending write address holds until accepted
  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    (m_awvalid_o && !m_awready_i) |=> (m_awvalid_o && $stable(m_awaddr_o)))
    else $error("AW valid or address changed before ready");

  // write data phase opens only after an accepted write address
  a_w_phase: assert property (@(posedge clk) disable iff (rst)
    $rose(m_wvalid_o) |-> $past((state == arb_idle) && m_awvalid_o && m_awready_i))
    else $error("W valid without an accepted write address");

endmodule

bind bus_arbiter bus_assertions #(
  .ADDR_W (ADDR_W)
) i_bus_assertions (
  .clk         (clk),
  .rst         (rst),
  .state       (state),
  .m_arvalid_o (m_arvalid_o),
  .m_arready_i (m_arready_i),
  .m_araddr_o  (m_araddr_o),
  .m_awvalid_o (m_awvalid_o),
  .m_awready_i (m_awready_i),
  .m_awaddr_o  (m_awaddr_o),
  .m_wvalid_o  (m_wvalid_o)
);

// File: verification/tb_bus_top.sv
`timescale 1ns/1ps

module tb_bus_top;
  import bus_pkg::*;

  localparam int N_FETCH = 30;
  localparam int N_LOAD  = 30;
  localparam int N_STORE = 20;
  localparam int N_PAIR  = 10;
  localparam int N_TIMER = 5;
  // a store is one transaction plus its readback, a pair and a timer round are two
  localparam int N_TRANS = N_FETCH + N_LOAD + 2 * N_STORE + 2 * N_PAIR + 2 * N_TIMER;
  // worst case is a store, three channels of up to five cycles each
  localparam int WORST_LAT  = 16;
  localparam int MAX_CYCLES = N_TRANS * WORST_LAT * 10;

  logic clk = 1'b0;
  logic rst;
  logic ifu_arvalid_i, lsu_arvalid_i, lsu_awvalid_i;
  logic [31:0] ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i, lsu_wdata_i;
  logic [7:0] lsu_rstrb_i, lsu_wstrb_i;
  logic [31:0] ifu_rdata_o, lsu_rdata_o;
  logic ifu_rvalid_o, lsu_rvalid_o, lsu_wready_o;
  logic m_arvalid_o, m_arready_i, m_rvalid_i, m_rready_o;
  logic m_awvalid_o, m_awready_i, m_wvalid_o, m_wready_i, m_wlast_o, m_bvalid_i, m_bready_o;
  logic [31:0] m_araddr_o, m_awaddr_o;
  logic [63:0] m_rdata_i, m_wdata_o;
  logic [7:0] m_wstrb_o;
  axi_size_t m_arsize_o, m_awsize_o;

  integer seed;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int cycle = 0;
  int run_cycles = 0;
  logic [7:0]  ref_mem [0:4095];
  logic [63:0] slv_mem [0:511];

  bus_top #(
    .ADDR_W    (32),
    .CLINT_DIV (4)
  ) i_dut (
    .clk (clk), .rst (rst),
    .ifu_arvalid_i (ifu_arvalid_i), .ifu_araddr_i (ifu_araddr_i),
    .ifu_rdata_o (ifu_rdata_o), .ifu_rvalid_o (ifu_rvalid_o),
    .lsu_arvalid_i (lsu_arvalid_i), .lsu_araddr_i (lsu_araddr_i),
    .lsu_rstrb_i (lsu_rstrb_i), .lsu_rdata_o (lsu_rdata_o), .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_awvalid_i (lsu_awvalid_i), .lsu_awaddr_i (lsu_awaddr_i),
    .lsu_wdata_i (lsu_wdata_i), .lsu_wstrb_i (lsu_wstrb_i), .lsu_wready_o (lsu_wready_o),
    .m_arvalid_o (m_arvalid_o), .m_arready_i (m_arready_i), .m_araddr_o (m_araddr_o),
    .m_arsize_o (m_arsize_o), .m_rvalid_i (m_rvalid_i), .m_rdata_i (m_rdata_i),
    .m_rready_o (m_rready_o), .m_awvalid_o (m_awvalid_o), .m_awready_i (m_awready_i),
    .m_awaddr_o (m_awaddr_o), .m_awsize_o (m_awsize_o), .m_wvalid_o (m_wvalid_o),
    .m_wready_i (m_wready_i), .m_wdata_o (m_wdata_o), .m_wstrb_o (m_wstrb_o),
    .m_wlast_o (m_wlast_o), .m_bvalid_i (m_bvalid_i), .m_bready_o (m_bready_o)
  );

  always #50 clk = ~clk;

  // run_cycles counts edges out of reset, the timer's time base
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (!rst)
    begin
      run_cycles <= run_cycles + 1;
    end
  end

  initial
  begin
    while (cycle < MAX_CYCLES)
    begin
      @(posedge clk);
    end
    $display("timeout: the bus stopped answering after %0d cycles", cycle);
    $display("Something failed");
    $finish;
  end

  // every address bit feeds the pattern
  function automatic logic [7:0] fill_byte(input logic [11:0] addr);
    return addr[7:0] ^ {addr[11:8], addr[11:8]} ^ 8'h5a;
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    int base;
    base = {addr[11:2], 2'b00};
    return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
  endfunction

  function automatic axi_size_t size_for_strb(input logic [7:0] strb);
    if (strb[3:0] == 4'h1)
      return size_byte;
    else if (strb[3:0] == 4'h3)
      return size_half;
    else if (strb[3:0] == 4'hf)
      return size_word;
    return size_byte;
  endfunction

  function automatic int pick_delay();
    return $random(seed) & 3;
  endfunction

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - errors_before);
  endtask

  // AXI slave memory, observes at the rising edge and drives at the falling edge
  initial
  begin : slave
    int ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
    bit rd_pend, b_pend;
    logic [31:0] rd_addr, wr_addr;
    logic nx_arready, nx_rvalid, nx_awready, nx_wready, nx_bvalid;
    logic [63:0] nx_rdata;
    {m_arready_i, m_rvalid_i, m_awready_i, m_wready_i, m_bvalid_i} = '0;
    m_rdata_i = '0;
    forever
    begin
      @(posedge clk);
      if (rst)
      begin
        {nx_arready, nx_rvalid, nx_awready, nx_wready, nx_bvalid} = '0;
        {rd_pend, b_pend} = '0;
        nx_rdata = '0;
        ar_cnt = pick_delay();
        aw_cnt = pick_delay();
        w_cnt  = pick_delay();
      end
      else
      begin
        if (m_rvalid_i)
        begin
          rd_pend   = 1'b0;
          nx_rvalid = 1'b0;
        end
        if (m_bvalid_i)
        begin
          b_pend    = 1'b0;
          nx_bvalid = 1'b0;
        end
        if (m_arvalid_o && m_arready_i)
        begin
          rd_addr    = m_araddr_o;
          rd_pend    = 1'b1;
          r_cnt      = pick_delay();
          nx_arready = 1'b0;
          ar_cnt     = pick_delay();
        end
        else if (m_arvalid_o)
        begin
          if (ar_cnt == 0)
            nx_arready = 1'b1;
          else
            ar_cnt--;
        end
        if (m_awvalid_o && m_awready_i)
        begin
          wr_addr    = m_awaddr_o;
          nx_awready = 1'b0;
          aw_cnt     = pick_delay();
        end
        else if (m_awvalid_o)
        begin
          if (aw_cnt == 0)
            nx_awready = 1'b1;
          else
            aw_cnt--;
        end
        if (m_wvalid_o && m_wready_i)
        begin
          for (int i = 0; i < 8; i++)
          begin
            if (m_wstrb_o[i])
              slv_mem[wr_addr[11:3]][8 * i +: 8] = m_wdata_o[8 * i +: 8];
          end
          nx_wready = 1'b0;
          w_cnt     = pick_delay();
          b_pend    = 1'b1;
          b_cnt     = pick_delay();
        end
        else if (m_wvalid_o)
        begin
          if (w_cnt == 0)
            nx_wready = 1'b1;
          else
            w_cnt--;
        end
        if (rd_pend && !nx_rvalid)
        begin
          if (r_cnt == 0)
          begin
            nx_rvalid = 1'b1;
            nx_rdata  = slv_mem[rd_addr[11:3]];
          end
          else
            r_cnt--;
        end
        if (b_pend && !nx_bvalid)
        begin
          if (b_cnt == 0)
            nx_bvalid = 1'b1;
          else
            b_cnt--;
        end
      end
      @(negedge clk);
      m_arready_i = nx_arready;
      m_rvalid_i  = nx_rvalid;
      m_rdata_i   = nx_rdata;
      m_awready_i = nx_awready;
      m_wready_i  = nx_wready;
      m_bvalid_i  = nx_bvalid;
    end
  end

  task automatic do_read(input bit is_load, input logic [31:0] addr, input logic [7:0] strb);
    logic [31:0] exp_data;
    axi_size_t exp_size;
    bit done;
    exp_data = ref_word(addr);
    exp_size = is_load ? size_for_strb(strb) : size_word;
    done = 1'b0;
    @(negedge clk);
    if (is_load)
    begin
      lsu_arvalid_i = 1'b1;
      lsu_araddr_i  = addr;
      lsu_rstrb_i   = strb;
    end
    else
    begin
      ifu_arvalid_i = 1'b1;
      ifu_araddr_i  = addr;
    end
    while (!done)
    begin
      @(posedge clk);
      if (m_arvalid_o && m_arready_i)
      begin
        compare("m_araddr_o", addr, m_araddr_o);
        compare("m_arsize_o", exp_size, m_arsize_o);
      end
      if (m_rvalid_i)
        compare("m_rready_o", 1, m_rready_o);
      if (is_load && lsu_rvalid_o)
      begin
        compare("lsu_rdata_o", exp_data, lsu_rdata_o);
        done = 1'b1;
      end
      if (!is_load && ifu_rvalid_o)
      begin
        compare("ifu_rdata_o", exp_data, ifu_rdata_o);
        done = 1'b1;
      end
    end
    @(negedge clk);
    lsu_arvalid_i = 1'b0;
    ifu_arvalid_i = 1'b0;
  endtask

  task automatic do_store(input logic [31:0] addr, input logic [31:0] data,
                          input logic [7:0] strb);
    logic [63:0] exp_wdata;
    logic [7:0] exp_wstrb;
    int off;
    int src;
    bit done;
    off = addr[1:0];
    // byte view: bus lane j carries core byte (j mod 4) - offset
    for (int j = 0; j < 8; j++)
    begin
      src = (j % 4) - off;
      exp_wdata[8 * j +: 8] = (src >= 0) ? data[8 * src +: 8] : 8'h00;
      exp_wstrb[j] = (src >= 0) && strb[src] && ((j / 4) == addr[2]);
    end
    done = 1'b0;
    @(negedge clk);
    lsu_awvalid_i = 1'b1;
    lsu_awaddr_i  = addr;
    lsu_wdata_i   = data;
    lsu_wstrb_i   = strb;
    while (!done)
    begin
      @(posedge clk);
      if (m_awvalid_o && m_awready_i)
      begin
        compare("m_awaddr_o", addr, m_awaddr_o);
        compare("m_awsize_o", size_for_strb(strb), m_awsize_o);
      end
      if (m_wvalid_o && m_wready_i)
      begin
        compare("m_wstrb_o", exp_wstrb, m_wstrb_o);
        compare("m_wdata_o", exp_wdata, m_wdata_o);
        compare("m_wlast_o", 1, m_wlast_o);
      end
      if (m_bvalid_i)
        compare("m_bready_o", 1, m_bready_o);
      done = lsu_wready_o;
    end
    @(negedge clk);
    lsu_awvalid_i = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i] && (i + off < 4))
        ref_mem[{addr[11:2], 2'b00} + off + i] = data[8 * i +: 8];
    end
  endtask

  task automatic do_pair(input logic [31:0] faddr, input logic [31:0] laddr);
    logic [31:0] exp_f, exp_l;
    bit first, f_done, l_done;
    exp_f = ref_word(faddr);
    exp_l = ref_word(laddr);
    {f_done, l_done} = '0;
    first = 1'b1;
    @(negedge clk);
    ifu_arvalid_i = 1'b1;
    ifu_araddr_i  = faddr;
    lsu_arvalid_i = 1'b1;
    lsu_araddr_i  = laddr;
    lsu_rstrb_i   = 8'h0f;
    while (!(f_done && l_done))
    begin
      @(posedge clk);
      if (m_arvalid_o && m_arready_i)
      begin
        compare("m_araddr_o", first ? laddr : faddr, m_araddr_o);
        first = 1'b0;
      end
      if (lsu_rvalid_o)
      begin
        compare("lsu_rdata_o", exp_l, lsu_rdata_o);
        l_done = 1'b1;
      end
      if (ifu_rvalid_o)
      begin
        // the fetch has to wait for the load
        compare("ifu_rvalid_o after load", 1, l_done);
        compare("ifu_rdata_o", exp_f, ifu_rdata_o);
        f_done = 1'b1;
      end
      @(negedge clk);
      if (l_done)
        lsu_arvalid_i = 1'b0;
      if (f_done)
        ifu_arvalid_i = 1'b0;
    end
  endtask

  task automatic do_timer_read(input bit hi, output logic [31:0] value);
    int t_req;
    int waited;
    @(negedge clk);
    lsu_arvalid_i = 1'b1;
    lsu_araddr_i  = hi ? CLINT_MTIME_HI : CLINT_MTIME_LO;
    lsu_rstrb_i   = 8'h0f;
    t_req  = run_cycles;
    waited = 0;
    do
    begin
      @(posedge clk);
      waited++;
      compare("m_arvalid_o", 0, m_arvalid_o);
    end
    while (!lsu_rvalid_o);
    value = lsu_rdata_o;
    // strobe is seen on the third edge after the request is driven
    compare("timer latency", 3, waited);
    if (hi)
      compare("mtime hi", 0, value);
    else
      compare("mtime lo in range", 1, (value >= t_req / 4) && (value <= run_cycles / 4));
    @(negedge clk);
    lsu_arvalid_i = 1'b0;
  endtask

  initial
  begin
    int err0;
    logic [31:0] addr, data, lo, hi;
    logic [7:0] strb;
    logic [63:0] prev_mtime, mtime_now;
    seed = 32'h726d6886;
    rst = 1'b1;
    {ifu_arvalid_i, lsu_arvalid_i, lsu_awvalid_i} = '0;
    {ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i, lsu_wdata_i} = '0;
    lsu_rstrb_i = '0;
    lsu_wstrb_i = '0;
    for (int a = 0; a < 4096; a++)
    begin
      ref_mem[a] = fill_byte(a[11:0]);
      slv_mem[a[11:3]][{a[2:0], 3'b000} +: 8] = fill_byte(a[11:0]);
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;

    err0 = errors;
    repeat (5)
    begin
      @(posedge clk);
      compare("m_arvalid_o", 0, m_arvalid_o);
      compare("m_awvalid_o", 0, m_awvalid_o);
      compare("m_wvalid_o", 0, m_wvalid_o);
      compare("ifu_rvalid_o", 0, ifu_rvalid_o);
      compare("lsu_rvalid_o", 0, lsu_rvalid_o);
      compare("lsu_wready_o", 0, lsu_wready_o);
    end
    end_test("reset", err0);

    err0 = errors;
    for (int n = 0; n < N_FETCH; n++)
      do_read(1'b0, $random(seed) & 32'hffc, 8'h0f);
    end_test("fetch", err0);

    err0 = errors;
    for (int n = 0; n < N_LOAD; n++)
    begin
      case ($random(seed) & 3)
        0: strb = 8'h01;
        1: strb = 8'h03;
        2: strb = 8'h0f;
        default: strb = 8'h0c;
      endcase
      addr = $random(seed) & (strb == 8'h01 ? 32'hfff : (strb == 8'h03 ? 32'hffe : 32'hffc));
      do_read(1'b1, addr, strb);
    end
    end_test("load", err0);

    err0 = errors;
    for (int n = 0; n < N_STORE; n++)
    begin
      case ($random(seed) & 3)
        0: strb = 8'h01;
        1: strb = 8'h03;
        2: strb = 8'h0f;
        default: strb = 8'h0c;
      endcase
      addr = $random(seed) & (strb == 8'h01 ? 32'hfff : (strb == 8'h03 ? 32'hffe : 32'hffc));
      data = $random(seed);
      do_store(addr, data, strb);
      do_read(1'b1, addr & 32'hffc, 8'h0f);
    end
    end_test("store", err0);

    err0 = errors;
    for (int n = 0; n < N_PAIR; n++)
      do_pair($random(seed) & 32'hffc, $random(seed) & 32'hffc);
    end_test("fetch and load", err0);

    err0 = errors;
    prev_mtime = '0;
    for (int n = 0; n < N_TIMER; n++)
    begin
      do_timer_read(1'b0, lo);
      do_timer_read(1'b1, hi);
      mtime_now = {hi, lo};
      compare("mtime not decreasing", 1, mtime_now >= prev_mtime);
      prev_mtime = mtime_now;
      repeat (pick_delay() * 3) @(negedge clk);
    end
    end_test("timer", err0);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: list.f
src/bus_pkg.sv
src/lane_align.sv
src/clint_timer.sv
src/bus_arbiter.sv
src/bus_top.sv
verification/bus_assertions.sv
verification/tb_bus_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_bus_top
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
